/* Bender.yml */
package:
  name: radio_core

sources:
  # RTL in compile order
  - files:
      - logic/radio_pkg.sv
      - logic/radio_settings.sv
      - logic/radio_sample_path.sv
      - logic/radio_readback.sv
      - logic/radio_core.sv

  # Testbench with its included model
  - target: test
    include_dirs:
      - sim
    files:
      - sim/radio_core_tb.sv

/* all.f */
+incdir+sim
logic/radio_pkg.sv
logic/radio_settings.sv
logic/radio_sample_path.sv
logic/radio_readback.sv
logic/radio_core.sv
sim/radio_core_tb.sv

/* logic/radio_core.sv */
/*
  Single channel radio core: settings bank, sample path and readback mux.
  All ports run on clk, with no clock crossing inside.
  Strobes are single cycle with no back-pressure. Every path has one cycle latency.
*/

`timescale 1ns/1ps

module radio_core #(
  parameter int unsigned RADIO_NUM = 0
) (
  input  logic                 clk,
  input  logic                 reset,
  // Settings bus
  input  radio_pkg::set_bus_t  i_set,
  // Converters
  input  radio_pkg::sample_t   i_rx,
  input  logic                 i_rx_stb,
  input  logic                 i_tx_stb,
  output radio_pkg::sample_t   o_tx,
  // Host samples
  input  radio_pkg::sample_t   i_tx_host,
  input  logic                 i_tx_host_stb,
  output radio_pkg::rx_word_t  o_rx,
  output logic                 o_rx_stb,
  // Shared radio time
  input  radio_pkg::time_t     i_vita_time,
  // Readback
  input  logic                 i_rb_stb,
  input  radio_pkg::addr_t     i_rb_addr,
  output logic                 o_rb_stb,
  output logic [63:0]          o_rb_data
);

  import radio_pkg::*;

  radio_cfg_t cfg;
  sample_t    rx_raw;
  count_t     rx_count;

  radio_settings u_settings (
    .clk   (clk),
    .reset (reset),
    .i_set (i_set),
    .o_cfg (cfg)
  );

  radio_sample_path u_sample_path (
    .clk           (clk),
    .reset         (reset),
    .i_cfg         (cfg),
    .i_tx_host     (i_tx_host),
    .i_tx_host_stb (i_tx_host_stb),
    .i_tx_stb      (i_tx_stb),
    .i_rx          (i_rx),
    .i_rx_stb      (i_rx_stb),
    .i_vita_time   (i_vita_time),
    .o_tx          (o_tx),
    .o_rx          (o_rx),
    .o_rx_stb      (o_rx_stb),
    .o_rx_raw      (rx_raw),
    .o_rx_count    (rx_count)
  );

  // TX word for readback is the live DAC word, idle word included
  radio_readback #(
    .RADIO_NUM (RADIO_NUM)
  ) u_readback (
    .clk         (clk),
    .reset       (reset),
    .i_rb_stb    (i_rb_stb),
    .i_rb_addr   (i_rb_addr),
    .i_cfg       (cfg),
    .i_vita_time (i_vita_time),
    .i_tx        (o_tx),
    .i_rx_raw    (rx_raw),
    .i_rx_count  (rx_count),
    .o_rb_stb    (o_rb_stb),
    .o_rb_data   (o_rb_data)
  );

endmodule

/* logic/radio_pkg.sv */
/*
  Shared types and address maps for the single channel radio core.
  Samples are packed {I, Q} with 16 bits per half. Radio time is in clock ticks.
  Settings and readback addresses share the 8-bit addr_t space.
*/

package radio_pkg;

  // Widths that carry a meaning
  typedef logic [7:0]  addr_t;
  typedef logic [31:0] data_t;
  typedef logic [31:0] sample_t;
  typedef logic [63:0] time_t;
  typedef logic [31:0] count_t;

  // Settings register addresses
  localparam addr_t SR_CTRL       = 8'h10;
  localparam addr_t SR_TEST       = 8'h11;
  localparam addr_t SR_CODEC_IDLE = 8'h12;

  // Bit positions inside the SR_CTRL word
  localparam int CTRL_RUN_TX   = 0;
  localparam int CTRL_RUN_RX   = 1;
  localparam int CTRL_LOOPBACK = 2;

  // Readback addresses
  localparam addr_t RB_VITA_TIME = 8'd0;
  localparam addr_t RB_TEST      = 8'd1;
  localparam addr_t RB_TXRX      = 8'd2;
  localparam addr_t RB_RADIO_NUM = 8'd3;
  localparam addr_t RB_RX_COUNT  = 8'd4;

  // One settings bus write
  typedef struct packed {
    logic  stb;
    addr_t addr;
    data_t data;
  } set_bus_t;

  // Live radio configuration
  typedef struct packed {
    logic    run_tx;
    logic    run_rx;
    logic    loopback;
    sample_t tx_idle;
    data_t   test_word;
  } radio_cfg_t;

  // Timestamped RX output word
  typedef struct packed {
    sample_t sample;
    time_t   stamp;
  } rx_word_t;

endpackage

/* logic/radio_readback.sv */
/*
  Registered readback mux. Every request is answered one clock later.
  The answer holds the values seen before the request edge.
  Unknown addresses return zero. RADIO_NUM is zero-extended to 64 bits.
*/

`timescale 1ns/1ps

module radio_readback #(
  parameter int unsigned RADIO_NUM = 0
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_rb_stb,
  input  radio_pkg::addr_t       i_rb_addr,
  input  radio_pkg::radio_cfg_t  i_cfg,
  input  radio_pkg::time_t       i_vita_time,
  input  radio_pkg::sample_t     i_tx,
  input  radio_pkg::sample_t     i_rx_raw,
  input  radio_pkg::count_t      i_rx_count,
  output logic                   o_rb_stb,
  output logic [63:0]            o_rb_data
);

  import radio_pkg::*;

  logic [63:0] rb_next;

  always_comb begin
    case (i_rb_addr)
      RB_VITA_TIME: rb_next = i_vita_time;
      RB_TEST:      rb_next = {i_rx_raw, i_cfg.test_word};
      RB_TXRX:      rb_next = {i_tx, i_rx_raw};
      RB_RADIO_NUM: rb_next = 64'(RADIO_NUM);
      RB_RX_COUNT:  rb_next = 64'(i_rx_count);
      default:      rb_next = '0;
    endcase
  end

  // Data only moves on a request so it stays stable between answers
  always_ff @(posedge clk) begin
    if (reset) begin
      o_rb_stb  <= 1'b0;
      o_rb_data <= '0;
    end else begin
      o_rb_stb <= i_rb_stb;
      if (i_rb_stb) begin
        o_rb_data <= rb_next;
      end
    end
  end

  a_rb_one_cycle: assert property (
    @(posedge clk) disable iff (reset)
    o_rb_stb == $past(i_rb_stb && !reset)
  ) else $error("readback answer not one cycle after request");

endmodule

/* logic/radio_sample_path.sv */
/*
  TX hold and idle mux, RX source select, timestamping and RX sample count.
  No back-pressure: every selected strobe with run_rx set is accepted.
  The host sample is held even while TX is stopped and shows once run_tx is set.
  o_rx_raw is combinational and follows the selected RX source every cycle.
*/

`timescale 1ns/1ps

module radio_sample_path (
  input  logic                   clk,
  input  logic                   reset,
  input  radio_pkg::radio_cfg_t  i_cfg,
  input  radio_pkg::sample_t     i_tx_host,
  input  logic                   i_tx_host_stb,
  input  logic                   i_tx_stb,
  input  radio_pkg::sample_t     i_rx,
  input  logic                   i_rx_stb,
  input  radio_pkg::time_t       i_vita_time,
  output radio_pkg::sample_t     o_tx,
  output radio_pkg::rx_word_t    o_rx,
  output logic                   o_rx_stb,
  output radio_pkg::sample_t     o_rx_raw,
  output radio_pkg::count_t      o_rx_count
);

  import radio_pkg::*;

  sample_t tx_hold;
  sample_t rx_sel;
  logic    rx_sel_stb;
  logic    rx_accept;

  // Last sample from the host
  always_ff @(posedge clk) begin
    if (reset) begin
      tx_hold <= '0;
    end else if (i_tx_host_stb) begin
      tx_hold <= i_tx_host;
    end
  end

  // DAC sees the idle word whenever TX is not running
  assign o_tx = i_cfg.run_tx ? tx_hold : i_cfg.tx_idle;

  // Digital loopback takes the DAC word on the DAC strobe
  always_comb begin
    if (i_cfg.loopback) begin
      rx_sel     = o_tx;
      rx_sel_stb = i_tx_stb;
    end else begin
      rx_sel     = i_rx;
      rx_sel_stb = i_rx_stb;
    end
  end

  assign o_rx_raw  = rx_sel;
  assign rx_accept = i_cfg.run_rx && rx_sel_stb;

  // Control side: output strobe and sample count
  always_ff @(posedge clk) begin
    if (reset) begin
      o_rx_stb   <= 1'b0;
      o_rx_count <= '0;
    end else begin
      o_rx_stb <= rx_accept;
      if (rx_accept) begin
        o_rx_count <= o_rx_count + count_t'(1);
      end
    end
  end

  // Payload side, valid only while o_rx_stb is high
  always_ff @(posedge clk) begin
    if (rx_accept) begin
      o_rx.sample <= rx_sel;
      o_rx.stamp  <= i_vita_time;
    end
  end

  // An RX word only leaves when RX was running at the accepting edge
  a_rx_needs_run: assert property (
    @(posedge clk) disable iff (reset)
    o_rx_stb |-> $past(i_cfg.run_rx)
  ) else $error("RX output strobe while run_rx was clear");

endmodule

/* logic/radio_settings.sv */
/*
  Settings bus register bank. A write is visible on o_cfg one clock after its strobe.
  Writes to addresses outside the SR_ map are dropped without any response.
  Only the low bits of SR_CTRL are used, the rest of the word is ignored.
*/

`timescale 1ns/1ps

module radio_settings (
  input  logic                   clk,
  input  logic                   reset,
  input  radio_pkg::set_bus_t    i_set,
  output radio_pkg::radio_cfg_t  o_cfg
);

  import radio_pkg::*;

  // Decoded write enables, one per register
  logic wr_ctrl;
  logic wr_test;
  logic wr_idle;

  always_comb begin
    wr_ctrl = 1'b0;
    wr_test = 1'b0;
    wr_idle = 1'b0;
    if (i_set.stb) begin
      case (i_set.addr)
        SR_CTRL:       wr_ctrl = 1'b1;
        SR_TEST:       wr_test = 1'b1;
        SR_CODEC_IDLE: wr_idle = 1'b1;
        default: begin
          // Unknown address, nothing to update
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      o_cfg <= '0;
    end else begin
      if (wr_ctrl) begin
        o_cfg.run_tx   <= i_set.data[CTRL_RUN_TX];
        o_cfg.run_rx   <= i_set.data[CTRL_RUN_RX];
        o_cfg.loopback <= i_set.data[CTRL_LOOPBACK];
      end
      if (wr_test) begin
        o_cfg.test_word <= i_set.data;
      end
      if (wr_idle) begin
        o_cfg.tx_idle <= i_set.data;
      end
    end
  end

  // The host must present a resolved address with every write strobe
  a_set_addr_known: assert property (
    @(posedge clk) disable iff (reset)
    i_set.stb |-> !$isunknown(i_set.addr)
  ) else $error("settings write with unknown address");

endmodule

/* sim/radio_model.svh */
/*
  Reference model of the radio core, included inside the testbench module.
  The includer imports radio_pkg and defines RADIO_NUM before the include.
  model_step is called once per rising edge with the inputs held over that edge.
*/

`ifndef RADIO_MODEL_SVH
`define RADIO_MODEL_SVH

// Modelled settings registers
logic        m_run_tx;
logic        m_run_rx;
logic        m_loopback;
sample_t     m_tx_idle;
data_t       m_test_word;

// Sample path state
sample_t     m_hold;
count_t      m_count;

// Expected registered outputs
logic        m_rx_stb;
sample_t     m_rx_sample;
time_t       m_rx_stamp;
logic        m_rb_stb;
logic [63:0] m_rb_data;

task automatic model_reset();
  m_run_tx    = 1'b0;
  m_run_rx    = 1'b0;
  m_loopback  = 1'b0;
  m_tx_idle   = '0;
  m_test_word = '0;
  m_hold      = '0;
  m_count     = '0;
  m_rx_stb    = 1'b0;
  m_rx_sample = '0;
  m_rx_stamp  = '0;
  m_rb_stb    = 1'b0;
  m_rb_data   = '0;
endtask

// DAC word as the modelled registers give it
function automatic sample_t model_dac();
  return m_run_tx ? m_hold : m_tx_idle;
endfunction

task automatic model_step(
  input set_bus_t set,
  input sample_t  adc,
  input logic     adc_stb,
  input logic     dac_stb,
  input sample_t  host,
  input logic     host_stb,
  input time_t    now,
  input logic     rb_req,
  input addr_t    rb_addr
);
  sample_t dac;
  sample_t src;
  logic    src_stb;
  dac     = model_dac();
  src     = m_loopback ? dac : adc;
  src_stb = m_loopback ? dac_stb : adc_stb;
  // Readback answers with the state before this edge
  m_rb_stb = rb_req;
  if (rb_req) begin
    case (rb_addr)
      RB_VITA_TIME: m_rb_data = now;
      RB_TEST:      m_rb_data = {src, m_test_word};
      RB_TXRX:      m_rb_data = {dac, src};
      RB_RADIO_NUM: m_rb_data = 64'(RADIO_NUM);
      RB_RX_COUNT:  m_rb_data = {32'd0, m_count};
      default:      m_rb_data = 64'd0;
    endcase
  end
  m_rx_stb = m_run_rx && src_stb;
  if (m_rx_stb) begin
    m_rx_sample = src;
    m_rx_stamp  = now;
    m_count     = m_count + 32'd1;
  end
  if (host_stb) begin
    m_hold = host;
  end
  // Control word bits 0 to 2 are run_tx, run_rx and loopback
  if (set.stb) begin
    if (set.addr == SR_CTRL) begin
      m_run_tx   = set.data[0];
      m_run_rx   = set.data[1];
      m_loopback = set.data[2];
    end else if (set.addr == SR_TEST) begin
      m_test_word = set.data;
    end else if (set.addr == SR_CODEC_IDLE) begin
      m_tx_idle = set.data;
    end
  end
endtask

`endif

/* sim/radio_core_tb.sv */
/*
  Random stimulus testbench for radio_core with RADIO_NUM set to 3.
  Inputs change on the falling edge and outputs are compared with the model
  on the next falling edge. RX and readback data are compared only with their strobe.
*/

`timescale 1ns/1ps

module radio_core_tb;

  import radio_pkg::*;

  localparam int unsigned RADIO_NUM      = 3;
  localparam int          NUM_CYCLES     = 2000;
  localparam int          TIMEOUT_CYCLES = NUM_CYCLES + NUM_CYCLES / 4;
  localparam int          CLK_PERIOD     = 40;

  logic        clk = 1'b0;
  logic        reset;
  set_bus_t    i_set;
  sample_t     i_rx;
  logic        i_rx_stb;
  logic        i_tx_stb;
  sample_t     i_tx_host;
  logic        i_tx_host_stb;
  time_t       i_vita_time;
  logic        i_rb_stb;
  addr_t       i_rb_addr;
  sample_t     o_tx;
  rx_word_t    o_rx;
  logic        o_rx_stb;
  logic        o_rb_stb;
  logic [63:0] o_rb_data;

  int cycle_count = 0;
  int error_count = 0;
  int check_count = 0;
  int rx_seen     = 0;
  int rb_seen     = 0;

  `include "radio_model.svh"

  radio_core #(
    .RADIO_NUM (RADIO_NUM)
  ) u_dut (
    .clk           (clk),
    .reset         (reset),
    .i_set         (i_set),
    .i_rx          (i_rx),
    .i_rx_stb      (i_rx_stb),
    .i_tx_stb      (i_tx_stb),
    .o_tx          (o_tx),
    .i_tx_host     (i_tx_host),
    .i_tx_host_stb (i_tx_host_stb),
    .o_rx          (o_rx),
    .o_rx_stb      (o_rx_stb),
    .i_vita_time   (i_vita_time),
    .i_rb_stb      (i_rb_stb),
    .i_rb_addr     (i_rb_addr),
    .o_rb_stb      (o_rb_stb),
    .o_rb_data     (o_rb_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  task automatic check_word(input string what, input logic [95:0] got, input logic [95:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("Fail %0t: %s expected %h got %h", $time, what, exp, got);
    end
  endtask

  task automatic check_outputs();
    check_word("o_tx", o_tx, model_dac());
    check_word("o_rx_stb", o_rx_stb, m_rx_stb);
    if (m_rx_stb) begin
      rx_seen++;
      check_word("o_rx sample", o_rx.sample, m_rx_sample);
      check_word("o_rx stamp", o_rx.stamp, m_rx_stamp);
    end
    check_word("o_rb_stb", o_rb_stb, m_rb_stb);
    if (m_rb_stb) begin
      rb_seen++;
      check_word("o_rb_data", o_rb_data, m_rb_data);
    end
  endtask

  // Quiet inputs, radio time keeps running
  task automatic drive_idle();
    i_set         = '0;
    i_rx          = '0;
    i_rx_stb      = 1'b0;
    i_tx_stb      = 1'b0;
    i_tx_host     = '0;
    i_tx_host_stb = 1'b0;
    i_rb_stb      = 1'b0;
    i_rb_addr     = '0;
    i_vita_time   = i_vita_time + 64'd1;
  endtask

  task automatic drive_random();
    int unsigned pick;
    pick          = $urandom_range(0, 3);
    i_set.stb     = ($urandom_range(0, 3) == 0);
    i_set.addr    = (pick == 0) ? SR_CTRL : (pick == 1) ? SR_TEST :
                    (pick == 2) ? SR_CODEC_IDLE : 8'h2a;
    i_set.data    = $urandom();
    i_rx          = $urandom();
    i_rx_stb      = ($urandom_range(0, 1) == 1);
    i_tx_stb      = ($urandom_range(0, 1) == 1);
    i_tx_host     = $urandom();
    i_tx_host_stb = ($urandom_range(0, 1) == 1);
    i_rb_stb      = ($urandom_range(0, 1) == 1);
    i_rb_addr     = addr_t'($urandom_range(0, 6));
    i_vita_time   = i_vita_time + 64'd1;
  endtask

  // One clock: model follows the edge, outputs checked half a period later
  task automatic advance_cycle();
    @(posedge clk);
    model_step(i_set, i_rx, i_rx_stb, i_tx_stb, i_tx_host, i_tx_host_stb,
               i_vita_time, i_rb_stb, i_rb_addr);
    @(negedge clk);
    check_outputs();
  endtask

  initial begin
    void'($urandom(15694));
    reset       = 1'b1;
    i_vita_time = '0;
    drive_idle();
    model_reset();
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_outputs();
    reset = 1'b0;
    // Nothing may come out before any stimulus
    repeat (4) begin
      advance_cycle();
      drive_idle();
    end
    drive_random();
    repeat (NUM_CYCLES) begin
      advance_cycle();
      drive_random();
    end
    $display("Checks: %0d, errors: %0d, RX words: %0d, readbacks: %0d",
             check_count, error_count, rx_seen, rb_seen);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule
